// ==== dv/trigger_crossbar_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module trigger_crossbar_tb import trigger_pkg::*; ();

	////////////////////////////////////////////////////////////
	// Constants and DUT signals

	localparam string		STIM_FILE = "dv/trigger_stim.txt";
	localparam int			MAX_STIM = 64;
	localparam int			PIPE_CYCLES = 3;
	localparam int			BUS_WAIT_LIMIT = 8;
	localparam int			MAX_PATTERNS = 100;
	//Worst line is the LED test with its settle time
	localparam int			CMD_CYCLES_MAX = 200;
	localparam logic[31:0]	LFSR_SEED = 32'h5f75;

	typedef logic[8*24-1:0] name_t;

	logic					clk_250mhz;
	logic					rst_n;
	logic					psel;
	logic					penable;
	logic					pwrite;
	reg_addr_t				paddr;
	reg_data_t				pwdata;
	wire reg_data_t			prdata;
	wire					pready;
	trig_vec_t				trig_in;
	wire trig_vec_t			trig_out;
	wire trig_vec_t			trig_in_led;
	wire trig_vec_t			trig_out_led;
	wire[RELAY_COUNT-1:0]	relay_a;
	wire[RELAY_COUNT-1:0]	relay_b;
	wire[RELAY_COUNT-1:0]	relay_state;

	trigger_crossbar_top UUT(
		.clk_250mhz(clk_250mhz),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.trig_in(trig_in),
		.trig_out(trig_out),
		.trig_in_led(trig_in_led),
		.trig_out_led(trig_out_led),
		.relay_a(relay_a),
		.relay_b(relay_b),
		.relay_state(relay_state)
	);

	//10 ns period
	initial clk_250mhz = 1'b0;
	always #5 clk_250mhz = ~clk_250mhz;

	////////////////////////////////////////////////////////////
	// Stimulus table and reference model

	logic[7:0]	stim_cmd[MAX_STIM];
	name_t		stim_name[MAX_STIM];
	logic[31:0]	stim_a[MAX_STIM];
	logic[31:0]	stim_b[MAX_STIM];
	int			stim_count;
	logic		stim_loaded;
	int			errors;
	logic[31:0]	lfsr_state;

	//Shadow of the routing words and relay states
	logic[ROUTE_WORD_WIDTH-1:0]	route_model[TRIG_CHANNELS];
	logic[RELAY_COUNT-1:0]		relay_model;

	//Taps 32 22 2 1
	function automatic logic[31:0] lfsr_next(input logic[31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	//One LFSR step per bit
	task automatic random_bits(input int n, output logic[31:0] value);
		value = '0;
		for(int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	//Walk the inputs, copy each into every output that selects it
	function automatic trig_vec_t routed_output(input trig_vec_t pins);
		trig_vec_t	fixed;
		trig_vec_t	result;
		fixed = pins ^ PN_SWAP_MASK;
		result = '0;
		for(int i = 0; i < TRIG_CHANNELS; i++) begin
			for(int o = 0; o < TRIG_CHANNELS; o++) begin
				if(route_model[o][XBAR_ENABLE_BIT] &&
					(route_model[o][TRIG_SEL_WIDTH-1:0] == TRIG_SEL_WIDTH'(i)))
					result[o] = fixed[i];
			end
		end
		return result;
	endfunction

	//Address map, bit 9 picks the relay block
	task automatic track_write(input reg_addr_t addr, input reg_data_t data);
		if(!addr[TARGET_SEL_BIT]) begin
			if(addr < reg_addr_t'(TRIG_CHANNELS))
				route_model[addr[TRIG_SEL_WIDTH-1:0]] = data[ROUTE_WORD_WIDTH-1:0];
		end
		else if(addr[TARGET_SEL_BIT-1:0] < TARGET_SEL_BIT'(RELAY_COUNT))
			relay_model[addr[RELAY_IDX_WIDTH-1:0]] = data[0];
	endtask

	task automatic load_stim();
		int				fd;
		int				n;
		logic[8*128-1:0]	line_buf;
		name_t			cmd_buf;
		name_t			name_buf;
		logic[31:0]		a;
		logic[31:0]		b;
		fd = $fopen(STIM_FILE, "r");
		if(fd == 0) begin
			errors++;
			$display("Cannot open stimulus file %s", STIM_FILE);
		end
		else begin
			while(!$feof(fd) && stim_count < MAX_STIM) begin
				line_buf = '0;
				cmd_buf = '0;
				name_buf = '0;
				n = $fgets(line_buf, fd);
				n = $sscanf(line_buf, "%s %s %h %h", cmd_buf, name_buf, a, b);
				//Skip blank lines and comment lines
				if(n < 1 || cmd_buf[7:0] == "#")
					continue;
				if(n == 4 && cmd_buf[8*24-1:8] == '0) begin
					stim_cmd[stim_count] = cmd_buf[7:0];
					stim_name[stim_count] = name_buf;
					stim_a[stim_count] = a;
					stim_b[stim_count] = b;
					stim_count++;
				end
				else begin
					errors++;
					$display("Malformed stimulus line after entry %0d", stim_count);
				end
			end
			$fclose(fd);
			if(stim_count == 0) begin
				errors++;
				$display("Stimulus file holds no commands");
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Bus and clock helpers

	//Sample point is 1 ns after the edge
	task automatic next_cycles(input int n);
		repeat(n) begin
			@(posedge clk_250mhz);
			#1;
		end
	endtask

	task automatic report_mismatch(input name_t test_name, input logic[31:0] expected,
		input logic[31:0] actual);
		errors++;
		$display("FAILED %0s: expected %h, got %h at %0t", test_name, expected, actual, $time);
	endtask

	//Setup, enable, then wait for ready
	task automatic bus_access(input reg_addr_t addr, input logic write, input reg_data_t wdata,
		output reg_data_t rdata);
		int	waited;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		next_cycles(1);
		penable = 1'b1;
		next_cycles(1);
		waited = 0;
		while(!pready && waited < BUS_WAIT_LIMIT) begin
			next_cycles(1);
			waited++;
		end
		if(!pready) begin
			errors++;
			$display("Register access to %h never got pready", addr);
		end
		else if(waited != 0) begin
			errors++;
			$display("Register access to %h took %0d cycles too many", addr, waited);
		end
		rdata = prdata;
		//Access completes on this edge
		next_cycles(1);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Test commands

	//New random routing, then one random pattern per cycle
	task automatic random_routing(input name_t test_name, input int count);
		trig_vec_t	expect_q[$];
		trig_vec_t	expected;
		logic[31:0]	bits;
		reg_data_t	rdata;
		for(int o = 0; o < TRIG_CHANNELS; o++) begin
			random_bits(ROUTE_WORD_WIDTH, bits);
			bus_access(reg_addr_t'(o), 1'b1, reg_data_t'(bits), rdata);
			track_write(reg_addr_t'(o), reg_data_t'(bits));
		end
		//Three patterns in flight at once
		for(int i = 0; i < count + PIPE_CYCLES - 1; i++) begin
			if(i < count) begin
				random_bits(TRIG_CHANNELS, bits);
				trig_in = trig_vec_t'(bits);
				expect_q.push_back(routed_output(trig_vec_t'(bits)));
			end
			next_cycles(1);
			if(i >= PIPE_CYCLES - 1) begin
				expected = expect_q.pop_front();
				if(trig_out !== expected)
					report_mismatch(test_name, 32'(expected), 32'(trig_out));
			end
		end
	endtask

	task automatic led_check(input name_t test_name, input int idx);
		trig_vec_t	in_mask;
		trig_vec_t	out_mask;
		trig_vec_t	in_exp;
		trig_vec_t	out_exp;
		//All corrected inputs low until old LEDs run out
		trig_in = PN_SWAP_MASK;
		next_cycles(LED_HOLD_CYCLES + 8);
		if(trig_in_led !== '0 || trig_out_led !== '0) begin
			errors++;
			$display("LEDs still lit before the edge in %0s", test_name);
		end
		in_mask = '0;
		in_mask[idx] = 1'b1;
		out_mask = routed_output(PN_SWAP_MASK ^ in_mask);
		trig_in = PN_SWAP_MASK ^ in_mask;
		//Input LED after sync plus one, output LED one later
		for(int k = 1; k <= LED_HOLD_CYCLES + 4; k++) begin
			next_cycles(1);
			in_exp = (k >= 3 && k < 3 + LED_HOLD_CYCLES) ? in_mask : '0;
			out_exp = (k >= 4 && k < 4 + LED_HOLD_CYCLES) ? out_mask : '0;
			if(trig_in_led !== in_exp)
				report_mismatch(test_name, 32'(in_exp), 32'(trig_in_led));
			if(trig_out_led !== out_exp)
				report_mismatch(test_name, 32'(out_exp), 32'(trig_out_led));
		end
	endtask

	task automatic relay_check(input name_t test_name, input int idx, input logic value);
		reg_addr_t				addr;
		reg_data_t				rdata;
		logic[RELAY_COUNT-1:0]	bit_mask;
		logic[RELAY_COUNT-1:0]	a_exp;
		logic[RELAY_COUNT-1:0]	b_exp;
		addr = reg_addr_t'(idx);
		addr[TARGET_SEL_BIT] = 1'b1;
		bus_access(addr, 1'b1, reg_data_t'(value), rdata);
		track_write(addr, reg_data_t'(value));
		bit_mask = '0;
		bit_mask[idx] = 1'b1;
		//Pulse is visible right after the write completes
		for(int k = 0; k <= RELAY_PULSE_CYCLES; k++) begin
			a_exp = (k < RELAY_PULSE_CYCLES && value) ? bit_mask : '0;
			b_exp = (k < RELAY_PULSE_CYCLES && !value) ? bit_mask : '0;
			if(relay_state !== relay_model)
				report_mismatch(test_name, 32'(relay_model), 32'(relay_state));
			if(relay_a !== a_exp)
				report_mismatch(test_name, 32'(a_exp), 32'(relay_a));
			if(relay_b !== b_exp)
				report_mismatch(test_name, 32'(b_exp), 32'(relay_b));
			next_cycles(1);
		end
		bus_access(addr, 1'b0, '0, rdata);
		if(rdata !== reg_data_t'(relay_model[idx]))
			report_mismatch(test_name, 32'(relay_model[idx]), 32'(rdata));
	endtask

	task automatic run_command(input int i);
		reg_data_t	rdata;
		case(stim_cmd[i])
			"W": begin
				bus_access(reg_addr_t'(stim_a[i]), 1'b1, reg_data_t'(stim_b[i]), rdata);
				track_write(reg_addr_t'(stim_a[i]), reg_data_t'(stim_b[i]));
			end
			"R": begin
				bus_access(reg_addr_t'(stim_a[i]), 1'b0, '0, rdata);
				if(rdata !== reg_data_t'(stim_b[i]))
					report_mismatch(stim_name[i], stim_b[i], 32'(rdata));
			end
			"T": begin
				trig_in = trig_vec_t'(stim_a[i]);
				next_cycles(PIPE_CYCLES);
				if(trig_out !== trig_vec_t'(stim_b[i]))
					report_mismatch(stim_name[i], stim_b[i], 32'(trig_out));
			end
			"X": begin
				if(stim_a[i] > 32'(MAX_PATTERNS)) begin
					errors++;
					$display("Too many random patterns asked for in %0s", stim_name[i]);
				end
				else
					random_routing(stim_name[i], stim_a[i]);
			end
			"L": begin
				if(stim_a[i] >= 32'(TRIG_CHANNELS)) begin
					errors++;
					$display("No such trigger input in %0s", stim_name[i]);
				end
				else
					led_check(stim_name[i], stim_a[i]);
			end
			"P": begin
				if(stim_a[i] >= 32'(RELAY_COUNT)) begin
					errors++;
					$display("No such relay in %0s", stim_name[i]);
				end
				else
					relay_check(stim_name[i], stim_a[i], stim_b[i][0]);
			end
			default: begin
				errors++;
				$display("Unknown command on stimulus entry %0d", i);
			end
		endcase
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence and watchdog

	initial begin
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		trig_in = '0;
		errors = 0;
		stim_count = 0;
		stim_loaded = 1'b0;
		lfsr_state = LFSR_SEED;
		relay_model = '0;
		for(int o = 0; o < TRIG_CHANNELS; o++)
			route_model[o] = '0;
		load_stim();
		stim_loaded = 1'b1;
		repeat(2) @(posedge clk_250mhz);
		#1;
		rst_n = 1'b1;
		for(int i = 0; i < stim_count; i++)
			run_command(i);
		next_cycles(2);
		$display("Stimulus entries run: %0d, errors: %0d", stim_count, errors);
		if(errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	//Budget scales with the number of entries
	initial begin
		int	limit_ns;
		wait(stim_loaded);
		limit_ns = (stim_count * CMD_CYCLES_MAX * 10 * 2) + 1000;
		#(limit_ns);
		$display("Timeout: run still going after %0d ns", limit_ns);
		$display("Stimulus entries run: incomplete, errors: %0d", errors);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/trigger_stim.txt ====
# Columns: command, test name, operand a, operand b, operands in hex
# W addr data, R addr expected, T pins expected_out, X patterns 0, L input 0, P relay value
T reset_out_ones      fff  000
T reset_out_zeros     000  000
R reset_route0        000  0000
R reset_route11       00b  0000
W route_out0          000  0010
W route_out1          001  0013
W route_out2          002  0013
W route_out3          003  001b
W route_out4          004  0015
W route_out5          005  0007
W route_out6          006  0016
W route_out7          007  001c
W route_out8          008  0011
W route_out9          009  0012
W route_out10         00a  0019
W route_out11         00b  0010
W unmapped_write      00c  001f
R unmapped_read       00c  0000
R unmapped_top        1ff  0000
R route_rb1           001  0013
R route_rb5           005  0007
R route_rb7           007  001c
T route_pins000       000  a51
T route_pins808       808  a5f
T route_pins29a       29a  f57
L led_in3             3    0
L led_in0             0    0
X random_route        28   0
P relay0_set          0    1
P relay0_clear        0    0
P relay2_set          2    1
R relay_unmapped      204  0000
R relay2_state        202  0001

// ==== hdl/activity_stretcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module activity_stretcher import trigger_pkg::*; (
	input wire				clk_250mhz,
	input wire				rst_n,

	//Signal to watch, one bit per channel
	input wire trig_vec_t	trig,

	//Stretched activity indication
	output trig_vec_t		led
);

	//Last value seen, for edge detect
	trig_vec_t					trig_prev;
	trig_vec_t					rise;

	//Remaining on-time per channel
	logic[LED_CNT_WIDTH-1:0]	hold_cnt[TRIG_CHANNELS];

	assign rise = trig & ~trig_prev;

	always_ff @(posedge clk_250mhz) begin
		if(!rst_n) begin
			trig_prev <= '0;
			for(int i = 0; i < TRIG_CHANNELS; i++)
				hold_cnt[i] <= '0;
		end
		else begin
			trig_prev <= trig;
			for(int i = 0; i < TRIG_CHANNELS; i++) begin
				//New edge restarts the hold
				if(rise[i])
					hold_cnt[i] <= LED_CNT_WIDTH'(LED_HOLD_CYCLES);
				else if(hold_cnt[i] != '0)
					hold_cnt[i] <= hold_cnt[i] - LED_CNT_WIDTH'(1);
			end
		end
	end

	//Lit while the count is running
	always_comb begin
		for(int i = 0; i < TRIG_CHANNELS; i++)
			led[i] = (hold_cnt[i] != '0);
	end

endmodule

`default_nettype wire

// ==== hdl/apb_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_decoder import trigger_pkg::*; (
	input wire				clk_250mhz,
	input wire				rst_n,

	//Upstream register bus
	input wire				psel,
	input wire				penable,
	input wire				pwrite,
	input wire reg_addr_t	paddr,
	input wire reg_data_t	pwdata,
	output reg_data_t		prdata,
	output logic			pready,

	//Downstream targets
	apb_if.requester		xbar_bus,
	apb_if.requester		relay_bus
);

	////////////////////////////////////////////////////////////
	// Request fan-out

	logic		req_relay;
	reg_addr_t	local_addr;

	assign req_relay = paddr[TARGET_SEL_BIT];

	//Targets see their own offset only
	always_comb begin
		local_addr					= paddr;
		local_addr[TARGET_SEL_BIT]	= 1'b0;
	end

	//Select goes to one target, the rest to both
	assign xbar_bus.psel		= psel && !req_relay;
	assign xbar_bus.penable		= penable;
	assign xbar_bus.pwrite		= pwrite;
	assign xbar_bus.paddr		= local_addr;
	assign xbar_bus.pwdata		= pwdata;

	assign relay_bus.psel		= psel && req_relay;
	assign relay_bus.penable	= penable;
	assign relay_bus.pwrite		= pwrite;
	assign relay_bus.paddr		= local_addr;
	assign relay_bus.pwdata		= pwdata;

	////////////////////////////////////////////////////////////
	// Reply mux

	//Target picked in the setup cycle, held for the access
	logic	active_relay;

	always_ff @(posedge clk_250mhz) begin
		if(!rst_n)
			active_relay <= 1'b0;
		else if(psel && !penable)
			active_relay <= req_relay;
	end

	assign prdata	= active_relay ? relay_bus.prdata : xbar_bus.prdata;
	assign pready	= active_relay ? relay_bus.pready : xbar_bus.pready;

endmodule

`default_nettype wire

// ==== hdl/apb_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface apb_if import trigger_pkg::*; ();

	//Request side
	logic		psel;
	logic		penable;
	logic		pwrite;
	reg_addr_t	paddr;
	reg_data_t	pwdata;

	//Reply side
	reg_data_t	prdata;
	logic		pready;

	//Bus master end
	modport requester(
		output psel, penable, pwrite, paddr, pwdata,
		input prdata, pready
	);

	//Register block end
	modport completer(
		input psel, penable, pwrite, paddr, pwdata,
		output prdata, pready
	);

endinterface

`default_nettype wire

// ==== hdl/crossbar_matrix.sv ====
`timescale 1ns/1ps
`default_nettype none

module crossbar_matrix import trigger_pkg::*; (
	input wire				clk_250mhz,
	input wire				rst_n,

	//Routing register access
	apb_if.completer		bus,

	//Synchronized inputs
	input wire trig_vec_t	trig_sync,

	//Routed outputs and their LEDs
	output trig_vec_t		trig_out,
	output trig_vec_t		trig_out_led
);

	////////////////////////////////////////////////////////////
	// Routing registers

	//One word per output, enable plus input index
	logic[ROUTE_WORD_WIDTH-1:0]	route[TRIG_CHANNELS];

	logic						addr_hit;
	logic[TRIG_SEL_WIDTH-1:0]	reg_idx;
	logic						access_done;
	reg_data_t					rd_data;

	//Words 0 to 11 exist, the rest of the block is empty
	assign addr_hit		= (bus.paddr < reg_addr_t'(TRIG_CHANNELS));
	assign reg_idx		= bus.paddr[TRIG_SEL_WIDTH-1:0];
	assign access_done	= bus.psel && bus.penable && bus.pready;

	always_comb begin
		rd_data = '0;
		if(addr_hit)
			rd_data = reg_data_t'(route[reg_idx]);
	end

	//Ready one cycle after penable goes high
	always_ff @(posedge clk_250mhz) begin
		if(!rst_n)
			bus.pready <= 1'b0;
		else
			bus.pready <= bus.psel && bus.penable && !bus.pready;
	end

	//Read data captured alongside ready
	always_ff @(posedge clk_250mhz) begin
		if(bus.psel && bus.penable && !bus.pready)
			bus.prdata <= rd_data;
	end

	//Writes land as the access completes
	always_ff @(posedge clk_250mhz) begin
		if(!rst_n) begin
			for(int i = 0; i < TRIG_CHANNELS; i++)
				route[i] <= '0;
		end
		else if(access_done && bus.pwrite && addr_hit)
			route[reg_idx] <= bus.pwdata[ROUTE_WORD_WIDTH-1:0];
	end

	////////////////////////////////////////////////////////////
	// Output mux

	trig_vec_t	route_next;

	//Disabled or out-of-range selects drive low
	always_comb begin
		for(int i = 0; i < TRIG_CHANNELS; i++) begin
			route_next[i] = 1'b0;
			if(route[i][XBAR_ENABLE_BIT] &&
				(route[i][TRIG_SEL_WIDTH-1:0] < TRIG_SEL_WIDTH'(TRIG_CHANNELS)))
				route_next[i] = trig_sync[route[i][TRIG_SEL_WIDTH-1:0]];
		end
	end

	//Output flop, last stage of the trigger pipeline
	always_ff @(posedge clk_250mhz) begin
		if(!rst_n)
			trig_out <= '0;
		else
			trig_out <= route_next;
	end

	activity_stretcher out_leds(
		.clk_250mhz(clk_250mhz),
		.rst_n(rst_n),
		.trig(trig_out),
		.led(trig_out_led)
	);

endmodule

`default_nettype wire

// ==== hdl/relay_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module relay_controller import trigger_pkg::*; (
	input wire					clk_250mhz,
	input wire					rst_n,

	//Relay register access
	apb_if.completer			bus,

	//Commanded position, for readback
	output logic[RELAY_COUNT-1:0]	relay_state,

	//H-bridge drive, a sets and b resets
	output logic[RELAY_COUNT-1:0]	relay_a,
	output logic[RELAY_COUNT-1:0]	relay_b
);

	////////////////////////////////////////////////////////////
	// Register access

	logic						addr_hit;
	logic[RELAY_IDX_WIDTH-1:0]	reg_idx;
	logic						write_done;
	reg_data_t					rd_data;

	assign addr_hit		= (bus.paddr < reg_addr_t'(RELAY_COUNT));
	assign reg_idx		= bus.paddr[RELAY_IDX_WIDTH-1:0];
	assign write_done	= bus.psel && bus.penable && bus.pready && bus.pwrite && addr_hit;

	//State in bit 0, unmapped reads zero
	always_comb begin
		rd_data = '0;
		if(addr_hit)
			rd_data[0] = relay_state[reg_idx];
	end

	always_ff @(posedge clk_250mhz) begin
		if(!rst_n)
			bus.pready <= 1'b0;
		else
			bus.pready <= bus.psel && bus.penable && !bus.pready;
	end

	always_ff @(posedge clk_250mhz) begin
		if(bus.psel && bus.penable && !bus.pready)
			bus.prdata <= rd_data;
	end

	////////////////////////////////////////////////////////////
	// Coil pulses

	//Remaining drive time per relay
	logic[RELAY_CNT_WIDTH-1:0]	pulse_cnt[RELAY_COUNT];
	logic[RELAY_COUNT-1:0]		pulse_active;

	always_ff @(posedge clk_250mhz) begin
		if(!rst_n) begin
			relay_state <= '0;
			for(int i = 0; i < RELAY_COUNT; i++)
				pulse_cnt[i] <= '0;
		end
		else begin
			for(int i = 0; i < RELAY_COUNT; i++) begin
				//Rewriting mid-pulse starts a fresh pulse
				if(write_done && (reg_idx == RELAY_IDX_WIDTH'(i))) begin
					relay_state[i]	<= bus.pwdata[0];
					pulse_cnt[i]	<= RELAY_CNT_WIDTH'(RELAY_PULSE_CYCLES);
				end
				else if(pulse_cnt[i] != '0)
					pulse_cnt[i] <= pulse_cnt[i] - RELAY_CNT_WIDTH'(1);
			end
		end
	end

	always_comb begin
		for(int i = 0; i < RELAY_COUNT; i++)
			pulse_active[i] = (pulse_cnt[i] != '0);
	end

	//Drive the side matching the new state
	assign relay_a = pulse_active & relay_state;
	assign relay_b = pulse_active & ~relay_state;

endmodule

`default_nettype wire

// ==== hdl/trigger_crossbar_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module trigger_crossbar_top import trigger_pkg::*; (
	input wire						clk_250mhz,
	input wire						rst_n,

	//Register bus from management
	input wire						psel,
	input wire						penable,
	input wire						pwrite,
	input wire reg_addr_t			paddr,
	input wire reg_data_t			pwdata,
	output wire reg_data_t			prdata,
	output wire						pready,

	//Trigger ports
	input wire trig_vec_t			trig_in,
	output wire trig_vec_t			trig_out,

	//Front panel LEDs
	output wire trig_vec_t			trig_in_led,
	output wire trig_vec_t			trig_out_led,

	//Latching relays for the bidirectional ports
	output wire[RELAY_COUNT-1:0]	relay_a,
	output wire[RELAY_COUNT-1:0]	relay_b,
	output wire[RELAY_COUNT-1:0]	relay_state
);

	////////////////////////////////////////////////////////////
	// Register bus split

	apb_if	xbar_bus();
	apb_if	relay_bus();

	apb_decoder decoder(
		.clk_250mhz(clk_250mhz),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.xbar_bus(xbar_bus),
		.relay_bus(relay_bus)
	);

	////////////////////////////////////////////////////////////
	// Trigger pipeline

	trig_vec_t	trig_sync;

	trigger_input_stage inputs(
		.clk_250mhz(clk_250mhz),
		.rst_n(rst_n),
		.trig_in(trig_in),
		.trig_sync(trig_sync),
		.trig_in_led(trig_in_led)
	);

	crossbar_matrix matrix(
		.clk_250mhz(clk_250mhz),
		.rst_n(rst_n),
		.bus(xbar_bus),
		.trig_sync(trig_sync),
		.trig_out(trig_out),
		.trig_out_led(trig_out_led)
	);

	////////////////////////////////////////////////////////////
	// Relays

	relay_controller relays(
		.clk_250mhz(clk_250mhz),
		.rst_n(rst_n),
		.bus(relay_bus),
		.relay_state(relay_state),
		.relay_a(relay_a),
		.relay_b(relay_b)
	);

endmodule

`default_nettype wire

// ==== hdl/trigger_input_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module trigger_input_stage import trigger_pkg::*; (
	input wire				clk_250mhz,
	input wire				rst_n,

	//Raw inputs from the pins, some inverted
	input wire trig_vec_t	trig_in,

	//Corrected and synchronized to clk_250mhz
	output trig_vec_t		trig_sync,

	//Front panel activity
	output trig_vec_t		trig_in_led
);

	////////////////////////////////////////////////////////////
	// Polarity fix and synchronizer

	//Undo the board-level P/N swaps
	trig_vec_t	trig_fixed;
	trig_vec_t	trig_meta;

	assign trig_fixed = trig_in ^ PN_SWAP_MASK;

	//Two flops, first one may go metastable
	always_ff @(posedge clk_250mhz) begin
		if(!rst_n) begin
			trig_meta	<= '0;
			trig_sync	<= '0;
		end
		else begin
			trig_meta	<= trig_fixed;
			trig_sync	<= trig_meta;
		end
	end

	////////////////////////////////////////////////////////////
	// Input LEDs

	//Stretch off the clean signal, not the raw pins
	activity_stretcher in_leds(
		.clk_250mhz(clk_250mhz),
		.rst_n(rst_n),
		.trig(trig_sync),
		.led(trig_in_led)
	);

endmodule

`default_nettype wire

// ==== hdl/trigger_pkg.sv ====
`default_nettype none

package trigger_pkg;

	////////////////////////////////////////////////////////////
	// Trigger path

	//Inputs and outputs on the front panel
	localparam int TRIG_CHANNELS = 12;
	localparam int TRIG_SEL_WIDTH = 4;

	typedef logic[TRIG_CHANNELS-1:0] trig_vec_t;

	//Inputs with P/N swapped in the board layout
	localparam trig_vec_t PN_SWAP_MASK = 12'h065;

	//Routing word layout, enable above the index
	localparam int XBAR_ENABLE_BIT = 4;
	localparam int ROUTE_WORD_WIDTH = XBAR_ENABLE_BIT + 1;

	//LED hold time in clocks
	localparam int LED_HOLD_CYCLES = 64;
	localparam int LED_CNT_WIDTH = $clog2(LED_HOLD_CYCLES + 1);

	////////////////////////////////////////////////////////////
	// Relays

	localparam int RELAY_COUNT = 4;
	localparam int RELAY_IDX_WIDTH = $clog2(RELAY_COUNT);

	//Coil drive time, long enough for the latch to flip
	localparam int RELAY_PULSE_CYCLES = 32;
	localparam int RELAY_CNT_WIDTH = $clog2(RELAY_PULSE_CYCLES + 1);

	////////////////////////////////////////////////////////////
	// Register bus

	localparam int REG_DATA_WIDTH = 16;
	localparam int REG_ADDR_WIDTH = 10;

	typedef logic[REG_ADDR_WIDTH-1:0] reg_addr_t;
	typedef logic[REG_DATA_WIDTH-1:0] reg_data_t;

	//Low half of the map is the matrix, high half the relays
	localparam int TARGET_SEL_BIT = 9;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the trigger crossbar testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 \
	--top-module trigger_crossbar_tb \
	-f sources.f \
	--Mdir obj_dir \
	-o trigger_crossbar_sim &&
./obj_dir/trigger_crossbar_sim | tee /dev/stderr | grep -x "Test OK" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// ==== sources.f ====
hdl/trigger_pkg.sv
hdl/apb_if.sv
hdl/activity_stretcher.sv
hdl/trigger_input_stage.sv
hdl/crossbar_matrix.sv
hdl/relay_controller.sv
hdl/apb_decoder.sv
hdl/trigger_crossbar_top.sv
dv/trigger_crossbar_tb.sv
